// File: src/mfPkg.sv
// Widths and tap counts are fixed at compile time; all data is two's complement and signed.
package mfPkg;

	// Width of one real input sample.
	localparam int sampleWidth = 12;
	// Width of each part of a template coefficient.
	localparam int coeffWidth = 12;
	// Width of each part of a Hilbert output sample.
	localparam int htWidth = 16;
	// One tap product is a 16x12 multiply plus one bit for the add of two such terms.
	localparam int prodWidth = htWidth + coeffWidth + 1;
	// Width of each part of the sum over all taps.
	localparam int accWidth = 32;

	// The FIR length and the counter that loads its coefficients.
	localparam int numTaps = 8;
	localparam int tapCountWidth = $clog2(numTaps);

	// Hilbert filter length, its centre delay and the shift on the imaginary sum.
	localparam int htLength = 7;
	localparam int htDelay = 3;
	localparam int htShift = 8;
	// Index 0 multiplies the newest sample.
	localparam int htCoeffs [htLength] = '{-54, 0, -163, 0, 163, 0, 54};

	// The squared magnitude needs twice the sum width, and its root needs the sum width.
	localparam int radWidth = 2 * accWidth;
	localparam int rootWidth = accWidth;
	// One result bit per root step.
	localparam int rootSteps = rootWidth;
	// Counts the square step, the root steps and the hand-over to DONE.
	localparam int magStepWidth = 6;

	// A template coefficient.
	typedef struct packed {
		logic signed [coeffWidth-1:0] re;
		logic signed [coeffWidth-1:0] im;
	} complexCoeffT;

	// An analytic sample from the Hilbert filter.
	typedef struct packed {
		logic signed [htWidth-1:0] re;
		logic signed [htWidth-1:0] im;
	} complexSampleT;

	// The registered product of one tap.
	typedef struct packed {
		logic signed [prodWidth-1:0] re;
		logic signed [prodWidth-1:0] im;
	} complexProdT;

	// The sum of all tap products.
	typedef struct packed {
		logic signed [accWidth-1:0] re;
		logic signed [accWidth-1:0] im;
	} complexAccT;

	typedef enum logic {LOADING, RUNNING} feederStateT;

	typedef enum logic [1:0] {IDLE, ROOT, DONE} magStateT;

endpackage

// File: src/hilbertFilter.sv
// Output rounding is a plain arithmetic shift; history is cleared only by reset.
`timescale 1ns/1ps

module hilbertFilter (
	input logic clock,
	input logic arstN,
	input logic sampleValid,
	output logic sampleReady,
	input logic signed [mfPkg::sampleWidth-1:0] sample,
	output logic htValid,
	input logic htReady,
	output mfPkg::complexSampleT htSample
);

	// The six older samples; the seventh tap is the sample being accepted.
	logic signed [mfPkg::sampleWidth-1:0] history [mfPkg::htLength-1];
	// All seven taps, newest first.
	logic signed [mfPkg::sampleWidth-1:0] taps [mfPkg::htLength];
	int imagSum;
	int imagShifted;
	mfPkg::complexSampleT nextSample;
	logic accept;

	// The output register is free when empty or when its sample leaves this cycle.
	assign sampleReady = !htValid || htReady;
	assign accept = sampleValid && sampleReady;

	// Line up the incoming sample in front of the stored history.
	always_comb begin
		taps[0] = sample;
		for (int i = 1; i < mfPkg::htLength; i++) begin
			taps[i] = history[i-1];
		end
	end

	// The imaginary part is the filtered line scaled down by the shift.
	// The real part is the centre tap, which matches the filter's group delay.
	always_comb begin
		imagSum = 0;
		for (int i = 0; i < mfPkg::htLength; i++) begin
			imagSum = imagSum + mfPkg::htCoeffs[i] * taps[i];
		end
		imagShifted = imagSum >>> mfPkg::htShift;
		nextSample.re = taps[mfPkg::htDelay];
		nextSample.im = imagShifted[mfPkg::htWidth-1:0];
	end

	// The delay line starts at zero so that pre-reset samples count as zero.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < mfPkg::htLength - 1; i++) begin
				history[i] <= '0;
			end
		end else if (accept) begin
			for (int i = 0; i < mfPkg::htLength - 1; i++) begin
				history[i] <= taps[i];
			end
		end
	end

	// Valid is set by an accepted input and cleared when the sample is taken.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			htValid <= 1'b0;
		end else if (accept) begin
			htValid <= 1'b1;
		end else if (htReady) begin
			htValid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			htSample <= nextSample;
		end
	end

endmodule

// File: src/tapFeeder.sv
// Loads exactly numTaps coefficients once per reset; a new template needs a new reset.
`timescale 1ns/1ps

module tapFeeder (
	input logic clock,
	input logic arstN,
	input logic coeffValid,
	output logic coeffReady,
	input mfPkg::complexCoeffT coeff,
	input logic htValid,
	output logic htReady,
	input mfPkg::complexSampleT htSample,
	input logic sumSpace,
	output logic coeffShift,
	output logic advance,
	output mfPkg::complexCoeffT feedCoeff,
	output mfPkg::complexSampleT feedSample
);

	mfPkg::feederStateT state;
	// Number of coefficients accepted so far.
	logic [mfPkg::tapCountWidth-1:0] loadCount;
	logic running;

	assign running = state == mfPkg::RUNNING;

	// Coefficients are taken only while loading.
	// Every transfer shifts the whole coefficient chain by one tap.
	assign coeffReady = state == mfPkg::LOADING;
	assign coeffShift = coeffValid && coeffReady;
	assign feedCoeff = coeff;

	// A sample moves into the taps only when the summer has room.
	// This keeps the product and sum registers from being overwritten.
	assign htReady = running && htValid && sumSpace;
	assign advance = htReady;
	assign feedSample = htSample;

	// The first coefficient ends in the last tap after numTaps shifts.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= mfPkg::LOADING;
			loadCount <= '0;
		end else begin
			case (state)
				mfPkg::LOADING: begin
					if (coeffShift) begin
						loadCount <= loadCount + 1'b1;
						// Stay in RUNNING until the next reset.
						if (loadCount == mfPkg::tapCountWidth'(mfPkg::numTaps - 1)) begin
							state <= mfPkg::RUNNING;
						end
					end
				end
				mfPkg::RUNNING: begin
					state <= mfPkg::RUNNING;
				end
				default: begin
					state <= mfPkg::LOADING;
					loadCount <= '0;
				end
			endcase
		end
	end

endmodule

// File: src/complexTap.sv
// Coefficients are only valid after the full template has been shifted in.
`timescale 1ns/1ps

module complexTap (
	input logic clock,
	input logic arstN,
	input logic coeffShift,
	input logic advance,
	input mfPkg::complexCoeffT coeffIn,
	output mfPkg::complexCoeffT coeffOut,
	input mfPkg::complexSampleT sampleIn,
	output mfPkg::complexSampleT sampleOut,
	output mfPkg::complexProdT product
);

	logic signed [mfPkg::prodWidth-1:0] prodRe;
	logic signed [mfPkg::prodWidth-1:0] prodIm;

	// Full complex product of this tap's coefficient and the incoming sample.
	assign prodRe = sampleIn.re * coeffOut.re - sampleIn.im * coeffOut.im;
	assign prodIm = sampleIn.re * coeffOut.im + sampleIn.im * coeffOut.re;

	// The coefficient moves one tap along the chain per load transfer.
	always_ff @(posedge clock) begin
		if (coeffShift) begin
			coeffOut <= coeffIn;
		end
	end

	// The held sample starts at zero and feeds the next tap one advance later.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			sampleOut <= '0;
		end else if (advance) begin
			sampleOut <= sampleIn;
		end
	end

	always_ff @(posedge clock) begin
		if (advance) begin
			product.re <= prodRe;
			product.im <= prodIm;
		end
	end

endmodule

// File: src/tapSummer.sv
// The products stage and the sum stage move together and hold under back-pressure.
`timescale 1ns/1ps

module tapSummer (
	input logic clock,
	input logic arstN,
	input logic advance,
	input mfPkg::complexProdT products [mfPkg::numTaps],
	output logic sumValid,
	input logic sumReady,
	output mfPkg::complexAccT sum,
	output logic sumSpace
);

	// Set one cycle after an advance, when the tap products hold a new item.
	logic productsValid;
	logic signed [mfPkg::accWidth-1:0] totalRe;
	logic signed [mfPkg::accWidth-1:0] totalIm;

	// The sum register is empty or leaving, so both stages can move.
	assign sumSpace = !sumValid || sumReady;

	// Add the sign-extended products of all taps.
	always_comb begin
		totalRe = '0;
		totalIm = '0;
		for (int i = 0; i < mfPkg::numTaps; i++) begin
			totalRe = totalRe + products[i].re;
			totalIm = totalIm + products[i].im;
		end
	end

	// When the sum cannot leave, both flags hold.
	// The feeder also stops advancing then, so the products hold as well.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			productsValid <= 1'b0;
			sumValid <= 1'b0;
		end else if (sumSpace) begin
			productsValid <= advance;
			sumValid <= productsValid;
		end
	end

	always_ff @(posedge clock) begin
		if (sumSpace && productsValid) begin
			sum.re <= totalRe;
			sum.im <= totalIm;
		end
	end

endmodule

// File: src/magnitudeUnit.sv
// Handles one sum at a time; the result is the floor of the root, with no further scaling.
`timescale 1ns/1ps

module magnitudeUnit (
	input logic clock,
	input logic arstN,
	input logic sumValid,
	output logic sumReady,
	input mfPkg::complexAccT sum,
	output logic resultValid,
	input logic resultReady,
	output logic [mfPkg::rootWidth-1:0] result
);

	mfPkg::magStateT state;
	// Step 0 squares, steps 1 to 32 find the root bits, the last step hands over to DONE.
	logic [mfPkg::magStepWidth-1:0] step;
	mfPkg::complexAccT operand;
	logic signed [mfPkg::radWidth-1:0] reSquare;
	logic signed [mfPkg::radWidth-1:0] imSquare;
	// Radicand bits still to be brought down, two per step.
	logic [mfPkg::radWidth-1:0] radicand;
	logic [mfPkg::rootWidth+1:0] remainder;
	logic [mfPkg::rootWidth-1:0] root;
	logic [mfPkg::rootWidth+3:0] trial;
	logic [mfPkg::rootWidth+3:0] subtrahend;
	logic [mfPkg::rootWidth+3:0] difference;
	logic fits;

	assign reSquare = operand.re * operand.re;
	assign imSquare = operand.im * operand.im;

	// Bring down the next bit pair and test the candidate 4*root + 1.
	assign trial = {remainder, radicand[mfPkg::radWidth-1 -: 2]};
	assign subtrahend = {2'b00, root, 2'b01};
	assign difference = trial - subtrahend;
	assign fits = trial >= subtrahend;

	assign sumReady = state == mfPkg::IDLE;
	assign resultValid = state == mfPkg::DONE;
	assign result = root;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= mfPkg::IDLE;
			step <= '0;
		end else begin
			case (state)
				mfPkg::IDLE: begin
					if (sumValid) begin
						state <= mfPkg::ROOT;
						step <= '0;
					end
				end
				mfPkg::ROOT: begin
					if (step == mfPkg::magStepWidth'(mfPkg::rootSteps + 1)) begin
						state <= mfPkg::DONE;
					end else begin
						step <= step + 1'b1;
					end
				end
				mfPkg::DONE: begin
					if (resultReady) begin
						state <= mfPkg::IDLE;
					end
				end
				default: begin
					state <= mfPkg::IDLE;
				end
			endcase
		end
	end

	// The sum of two squares fits the radicand as an unsigned number.
	// A failed trial restores the remainder by keeping the trial value.
	always_ff @(posedge clock) begin
		if (sumValid && sumReady) begin
			operand <= sum;
		end
		if (state == mfPkg::ROOT) begin
			if (step == '0) begin
				radicand <= reSquare + imSquare;
				remainder <= '0;
				root <= '0;
			end else if (step <= mfPkg::magStepWidth'(mfPkg::rootSteps)) begin
				radicand <= radicand << 2;
				remainder <= fits ? difference[mfPkg::rootWidth+1:0] : trial[mfPkg::rootWidth+1:0];
				root <= {root[mfPkg::rootWidth-2:0], fits};
			end
		end
	end

endmodule

// File: src/matchedFilter.sv
// Samples are refused until the whole template is loaded; one result leaves per sample.
`timescale 1ns/1ps

module matchedFilter (
	input logic clock,
	input logic arstN,
	input logic coeffValid,
	output logic coeffReady,
	input mfPkg::complexCoeffT coeff,
	input logic sampleValid,
	output logic sampleReady,
	input logic signed [mfPkg::sampleWidth-1:0] sample,
	output logic resultValid,
	input logic resultReady,
	output logic [mfPkg::rootWidth-1:0] result
);

	logic loaded;
	logic hilbertValid;
	logic hilbertReady;
	logic htValid;
	logic htReady;
	mfPkg::complexSampleT htSample;
	logic sumSpace;
	logic coeffShift;
	logic advance;
	logic sumValid;
	logic sumReady;
	mfPkg::complexAccT sum;
	// Entry i is the coefficient and sample that tap i reads.
	mfPkg::complexCoeffT coeffChain [mfPkg::numTaps];
	mfPkg::complexSampleT sampleChain [mfPkg::numTaps];
	mfPkg::complexProdT products [mfPkg::numTaps];

	// The coefficient stream closes for good once loading is over.
	// Gate the sample stream on that so no sample enters during loading.
	assign loaded = !coeffReady;
	assign hilbertValid = sampleValid && loaded;
	assign sampleReady = hilbertReady && loaded;

	hilbertFilter hilbert0 (
		.clock(clock),
		.arstN(arstN),
		.sampleValid(hilbertValid),
		.sampleReady(hilbertReady),
		.sample(sample),
		.htValid(htValid),
		.htReady(htReady),
		.htSample(htSample)
	);

	tapFeeder feeder0 (
		.clock(clock),
		.arstN(arstN),
		.coeffValid(coeffValid),
		.coeffReady(coeffReady),
		.coeff(coeff),
		.htValid(htValid),
		.htReady(htReady),
		.htSample(htSample),
		.sumSpace(sumSpace),
		.coeffShift(coeffShift),
		.advance(advance),
		.feedCoeff(coeffChain[0]),
		.feedSample(sampleChain[0])
	);

	// Each tap passes its coefficient and sample on; the last tap's outputs end the chain.
	for (genvar i = 0; i < mfPkg::numTaps; i++) begin : gTap
		if (i < mfPkg::numTaps - 1) begin : gMid
			complexTap tap (
				.clock(clock),
				.arstN(arstN),
				.coeffShift(coeffShift),
				.advance(advance),
				.coeffIn(coeffChain[i]),
				.coeffOut(coeffChain[i+1]),
				.sampleIn(sampleChain[i]),
				.sampleOut(sampleChain[i+1]),
				.product(products[i])
			);
		end else begin : gLast
			complexTap tap (
				.clock(clock),
				.arstN(arstN),
				.coeffShift(coeffShift),
				.advance(advance),
				.coeffIn(coeffChain[i]),
				.coeffOut(),
				.sampleIn(sampleChain[i]),
				.sampleOut(),
				.product(products[i])
			);
		end
	end

	tapSummer summer0 (
		.clock(clock),
		.arstN(arstN),
		.advance(advance),
		.products(products),
		.sumValid(sumValid),
		.sumReady(sumReady),
		.sum(sum),
		.sumSpace(sumSpace)
	);

	magnitudeUnit magnitude0 (
		.clock(clock),
		.arstN(arstN),
		.sumValid(sumValid),
		.sumReady(sumReady),
		.sum(sum),
		.resultValid(resultValid),
		.resultReady(resultReady),
		.result(result)
	);

endmodule

// File: bench/mfModel.svh
// Reference model for the including testbench; call clearModel after every DUT reset.
`ifndef MF_MODEL_SVH
`define MF_MODEL_SVH

// Real input samples, newest first, zero before the first accepted sample.
int xHist [mfPkg::htLength];
// Analytic samples from the Hilbert rule, newest first.
longint sRe [mfPkg::numTaps];
longint sIm [mfPkg::numTaps];
// The template in the order it was accepted.
longint cRe [mfPkg::numTaps];
longint cIm [mfPkg::numTaps];
int coeffsLoaded;
// Expected magnitudes, oldest first.
longint expectedQ [$];

// Floor square root from the floating-point estimate, corrected to the exact integer.
function automatic longint floorSqrt(longint x);
	longint r;
	r = longint'($floor($sqrt(real'(x))));
	while (r * r > x) begin
		r = r - 1;
	end
	while ((r + 1) * (r + 1) <= x) begin
		r = r + 1;
	end
	return r;
endfunction

// Clears all history, so that samples before the reset count as zero.
function automatic void clearModel();
	for (int i = 0; i < mfPkg::htLength; i++) begin
		xHist[i] = 0;
	end
	for (int i = 0; i < mfPkg::numTaps; i++) begin
		sRe[i] = 0;
		sIm[i] = 0;
	end
	coeffsLoaded = 0;
	expectedQ.delete();
endfunction

function automatic void storeCoeff(longint re, longint im);
	cRe[coeffsLoaded] = re;
	cIm[coeffsLoaded] = im;
	coeffsLoaded++;
endfunction

// Applies the Hilbert rule, then the correlation, then queues the magnitude.
function automatic void predictResult(int x);
	int imSum;
	longint yRe;
	longint yIm;
	int d;
	for (int i = mfPkg::htLength - 1; i > 0; i--) begin
		xHist[i] = xHist[i-1];
	end
	xHist[0] = x;
	imSum = 0;
	for (int i = 0; i < mfPkg::htLength; i++) begin
		imSum = imSum + mfPkg::htCoeffs[i] * xHist[i];
	end
	for (int i = mfPkg::numTaps - 1; i > 0; i--) begin
		sRe[i] = sRe[i-1];
		sIm[i] = sIm[i-1];
	end
	// The real part is the centre sample, the imaginary part the scaled filter sum.
	sRe[0] = xHist[mfPkg::htDelay];
	sIm[0] = imSum >>> mfPkg::htShift;
	yRe = 0;
	yIm = 0;
	// Coefficient k meets the sample delayed by numTaps-1-k.
	for (int k = 0; k < mfPkg::numTaps; k++) begin
		d = mfPkg::numTaps - 1 - k;
		yRe = yRe + cRe[k] * sRe[d] - cIm[k] * sIm[d];
		yIm = yIm + cRe[k] * sIm[d] + cIm[k] * sRe[d];
	end
	expectedQ.push_back(floorSqrt(yRe * yRe + yIm * yIm));
endfunction

`endif

// File: bench/tbMatchedFilter.sv
// Four stimulus phases over three resets; the run is cut off at a cycle limit set by sample count.
`timescale 1ns/1ps

module tbMatchedFilter;

	// Samples per phase, and the cycle limit that follows from them.
	localparam int randomCount = 200;
	localparam int pressureCount = 200;
	localparam int fullScaleCount = 100;
	localparam int reloadCount = 100;
	localparam int totalSamples = randomCount + pressureCount + fullScaleCount + reloadCount;
	localparam int cycleLimit = 40 * totalSamples + 1000;
	localparam int seed = 79;
	// Longer than one magnitude latency, so a repeated last result still shows up.
	localparam int drainCycles = 40;

	logic clock;
	logic arstN;
	logic coeffValid;
	logic coeffReady;
	mfPkg::complexCoeffT coeff;
	logic sampleValid;
	logic sampleReady;
	logic signed [mfPkg::sampleWidth-1:0] sample;
	logic resultValid;
	logic resultReady;
	logic [mfPkg::rootWidth-1:0] result;

	string testName;
	int valueErrors;
	int flagErrors;
	int protocolErrors;
	int resultsChecked;
	int cycleCount;
	int gapPercent;
	int readyPercent;
	int sampleQ [$];
	mfPkg::complexCoeffT coeffQ [$];
	// A result that was offered but not taken must still be there, unchanged.
	logic pendingResult;
	logic [mfPkg::rootWidth-1:0] pendingValue;

	`include "mfModel.svh"

	matchedFilter dut0 (
		.clock(clock),
		.arstN(arstN),
		.coeffValid(coeffValid),
		.coeffReady(coeffReady),
		.coeff(coeff),
		.sampleValid(sampleValid),
		.sampleReady(sampleReady),
		.sample(sample),
		.resultValid(resultValid),
		.resultReady(resultReady),
		.result(result)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#4 clock = ~clock;
		end
	end

	always @(posedge clock) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout in %s after %0d cycles, %0d results never arrived", testName,
				cycleCount, expectedQ.size());
			$display("Summary: %0d results checked, %0d value, %0d flag, %0d protocol errors",
				resultsChecked, valueErrors, flagErrors, protocolErrors);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic checkFlag(string what, logic expected, logic actual);
		if (actual !== expected) begin
			$display("FAILED %s %s: expected %0b, actual %0b", testName, what, expected, actual);
			flagErrors++;
		end
	endtask

	// Observe at the falling edge, where everything is stable, then drive at the rising edge.
	task automatic stepCycle();
		logic coeffFire;
		logic sampleFire;
		logic resultFire;
		longint expected;
		@(negedge clock);
		coeffFire = coeffValid && coeffReady;
		sampleFire = sampleValid && sampleReady;
		resultFire = resultValid && resultReady;
		// Samples stay blocked until the whole template is in; then loading is closed.
		if (coeffsLoaded < mfPkg::numTaps) begin
			checkFlag("sampleReady while loading", 1'b0, sampleReady);
			checkFlag("coeffReady while loading", 1'b1, coeffReady);
		end else begin
			checkFlag("coeffReady after loading", 1'b0, coeffReady);
		end
		if (pendingResult) begin
			checkFlag("resultValid while held", 1'b1, resultValid);
			if (result !== pendingValue) begin
				$display("FAILED %s result hold: expected %0d, actual %0d", testName,
					pendingValue, result);
				flagErrors++;
			end
		end
		pendingResult = resultValid && !resultReady;
		pendingValue = result;
		if (coeffFire) begin
			storeCoeff(coeff.re, coeff.im);
		end
		// Every result on offer must belong to an accepted sample still waiting for it.
		if (resultValid && expectedQ.size() == 0) begin
			$display("%s: a result came out with no accepted sample left to match it",
				testName);
			protocolErrors++;
		end else if (resultFire) begin
			expected = expectedQ.pop_front();
			resultsChecked++;
			if (longint'(result) != expected) begin
				$display("FAILED %s: expected %0d, actual %0d", testName, expected, result);
				valueErrors++;
			end
		end
		if (sampleFire) begin
			predictResult(int'(sample));
		end
		@(posedge clock);
		// New data only when the stream is idle or its item was just taken.
		if (!coeffValid || coeffFire) begin
			if (coeffQ.size() > 0) begin
				coeffValid <= 1'b1;
				coeff <= coeffQ.pop_front();
			end else begin
				coeffValid <= 1'b0;
			end
		end
		if (!sampleValid || sampleFire) begin
			if (sampleQ.size() > 0 && $urandom_range(99) >= gapPercent) begin
				sampleValid <= 1'b1;
				sample <= mfPkg::sampleWidth'(sampleQ.pop_front());
			end else begin
				sampleValid <= 1'b0;
			end
		end
		resultReady <= ($urandom_range(99) < readyPercent);
	endtask

	// Reset held for two cycles, then the state right after reset is checked.
	task automatic resetDut(string name);
		testName = name;
		@(posedge clock);
		arstN <= 1'b0;
		coeffValid <= 1'b0;
		sampleValid <= 1'b0;
		repeat (2) @(posedge clock);
		arstN <= 1'b1;
		clearModel();
		pendingResult = 1'b0;
		coeffQ.delete();
		sampleQ.delete();
		@(negedge clock);
		checkFlag("coeffReady after reset", 1'b1, coeffReady);
		checkFlag("sampleReady after reset", 1'b0, sampleReady);
		checkFlag("resultValid after reset", 1'b0, resultValid);
	endtask

	// Full-scale parts take only the two extreme values.
	task automatic loadTemplate(logic fullScale);
		mfPkg::complexCoeffT c;
		for (int k = 0; k < mfPkg::numTaps; k++) begin
			if (fullScale) begin
				c.re = $urandom_range(1) ? 12'sh7FF : 12'sh800;
				c.im = $urandom_range(1) ? 12'sh7FF : 12'sh800;
			end else begin
				c.re = mfPkg::coeffWidth'($urandom_range(4095));
				c.im = mfPkg::coeffWidth'($urandom_range(4095));
			end
			coeffQ.push_back(c);
		end
	endtask

	// Runs until every sample has been sent and every expected result has arrived.
	task automatic runPhase(string name, int count, logic fullScale, int gap, int ready);
		testName = name;
		gapPercent = gap;
		readyPercent = ready;
		for (int i = 0; i < count; i++) begin
			if (fullScale) begin
				sampleQ.push_back((i % 2 == 0) ? 2047 : -2048);
			end else begin
				sampleQ.push_back(int'($urandom_range(4095)) - 2048);
			end
		end
		while (sampleQ.size() > 0 || sampleValid || expectedQ.size() > 0) begin
			stepCycle();
		end
		// Keep watching so that a result with no sample behind it is caught.
		repeat (drainCycles) begin
			stepCycle();
		end
	endtask

	initial begin
		arstN = 1'b0;
		coeffValid = 1'b0;
		coeff = '0;
		sampleValid = 1'b0;
		sample = '0;
		resultReady = 1'b0;
		valueErrors = 0;
		flagErrors = 0;
		protocolErrors = 0;
		resultsChecked = 0;
		cycleCount = 0;
		pendingResult = 1'b0;
		pendingValue = '0;
		void'($urandom(seed));
		resetDut("firstReset");
		loadTemplate(1'b0);
		runPhase("randomSamples", randomCount, 1'b0, 30, 100);
		runPhase("backPressure", pressureCount, 1'b0, 30, 30);
		resetDut("fullScaleReset");
		loadTemplate(1'b1);
		runPhase("fullScale", fullScaleCount, 1'b1, 0, 100);
		// A new template after another reset must start from zero history.
		resetDut("reloadReset");
		loadTemplate(1'b0);
		runPhase("reload", reloadCount, 1'b0, 30, 100);
		$display("Summary: %0d results checked, %0d value, %0d flag, %0d protocol errors",
			resultsChecked, valueErrors, flagErrors, protocolErrors);
		if (valueErrors + flagErrors + protocolErrors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+bench
src/mfPkg.sv
src/hilbertFilter.sv
src/tapFeeder.sv
src/complexTap.sv
src/tapSummer.sv
src/magnitudeUnit.sv
src/matchedFilter.sv
bench/tbMatchedFilter.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it, and scans the log for the fail message.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tbMatchedFilter -f build.f \
	--Mdir obj_dir -o simMatchedFilter
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simMatchedFilter > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
	exit 1
fi
exit 0
